// File: Makefile
SIM  := obj_dir/Vnoc_dest_filter_tb
SRCS := $(wildcard *.sv *.svh) verilog.f

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert --top-module noc_dest_filter_tb -f verilog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: noc_dest_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_dest_checker import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  logic           in_head,
  input  logic           in_tail,
  input  noc_flit_word_u in_word,
  output logic           in_ready,
  output logic           fwd_valid,
  output logic           fwd_head,
  output logic           fwd_tail,
  output noc_flit_word_u fwd_word,
  input  logic           fwd_ready
);

  noc_header_t    in_hdr;
  logic           dest_invalid;
  logic           route_err_q;
  logic           route_err;
  logic           head_ok;
  logic           flit_ok;
  logic           pass_valid;
  logic           pass_ready;
  logic           head_fire;
  logic           req_busy;
  logic           rsp_busy;

  logic           req_valid;
  logic           req_ready;
  logic           hdr_valid;
  noc_header_t    err_hdr;
  logic           hdr_taken;
  logic           rsp_start;
  noc_header_t    rsp_hdr;
  logic [3:0]     rsp_beats;
  logic           rsp_valid;
  logic           rsp_head;
  logic           rsp_tail;
  noc_flit_word_u rsp_word;
  logic           rsp_ready;
  logic           rsp_done;

  assign in_hdr       = in_word.header;
  assign dest_invalid = in_hdr.invalid_destination ||
                        (int'(in_hdr.dest_x) >= `NOC_SIZE_X) ||
                        (int'(in_hdr.dest_y) >= `NOC_SIZE_Y);

  // heads decide the route, body flits follow the latched one.
  assign route_err  = in_head ? dest_invalid : route_err_q;
  assign head_ok    = !req_busy && !rsp_busy;
  assign flit_ok    = in_valid && (!in_head || head_ok);
  assign pass_valid = flit_ok && !route_err;
  assign req_valid  = flit_ok && route_err;
  assign pass_ready = fwd_ready && !rsp_busy;
  assign in_ready   = (!in_head || head_ok) && (route_err ? req_ready : pass_ready);
  assign head_fire  = in_valid && in_ready && in_head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_err_q <= 1'b0;
      req_busy    <= 1'b0;
      rsp_busy    <= 1'b0;
    end else begin
      if (head_fire) begin
        route_err_q <= dest_invalid;
      end
      if (req_valid && req_ready && in_tail) begin
        req_busy <= 1'b0;
      end else if (head_fire && dest_invalid) begin
        req_busy <= 1'b1;
      end
      if (rsp_done) begin
        rsp_busy <= 1'b0;
      end else if (head_fire && dest_invalid && is_non_posted(in_hdr.packet_type)) begin
        rsp_busy <= 1'b1;  // owns the output until the response tail.
      end
    end
  end

  noc_error_request_sink u_sink (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_head  (in_head),
    .req_tail  (in_tail),
    .req_word  (in_word),
    .req_ready (req_ready),
    .hdr_valid (hdr_valid),
    .hdr       (err_hdr),
    .hdr_taken (hdr_taken)
  );

  // a write answers only once its payload is gone.
  assign hdr_taken = hdr_valid && !req_busy;
  assign rsp_start = hdr_taken && is_non_posted(err_hdr.packet_type);
  assign rsp_beats = response_has_data(err_hdr.packet_type) ? err_hdr.burst_length : 4'd0;

  always_comb begin
    rsp_hdr = '0;
    rsp_hdr.packet_type  = response_has_data(err_hdr.packet_type) ?
                           noc_response_with_data : noc_response;
    rsp_hdr.dest_x       = err_hdr.src_x;
    rsp_hdr.dest_y       = err_hdr.src_y;
    rsp_hdr.src_x        = err_hdr.dest_x;
    rsp_hdr.src_y        = err_hdr.dest_y;
    rsp_hdr.tag          = err_hdr.tag;
    rsp_hdr.burst_length = rsp_beats;
    rsp_hdr.status       = noc_decode_error;
  end

  noc_error_response_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .rsp_start (rsp_start),
    .rsp_hdr   (rsp_hdr),
    .rsp_beats (rsp_beats),
    .rsp_valid (rsp_valid),
    .rsp_head  (rsp_head),
    .rsp_tail  (rsp_tail),
    .rsp_word  (rsp_word),
    .rsp_ready (rsp_ready),
    .rsp_done  (rsp_done)
  );

  // merge point.
  assign rsp_ready = fwd_ready && rsp_busy;
  assign fwd_valid = rsp_busy ? rsp_valid : pass_valid;
  assign fwd_head  = rsp_busy ? rsp_head  : in_head;
  assign fwd_tail  = rsp_busy ? rsp_tail  : in_tail;
  assign fwd_word  = rsp_busy ? rsp_word  : in_word;

endmodule

`default_nettype wire

// File: noc_dest_filter_properties.sv
`default_nettype none
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_dest_filter_properties (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       out_valid,
  input logic                       out_head,
  input logic                       out_tail,
  input logic [`NOC_DATA_WIDTH-1:0] out_word,
  input logic                       out_ready
);

  logic in_packet;  // between a head and its tail.
  int   fail_count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_packet <= 1'b0;
    end else if (out_valid && out_ready) begin
      in_packet <= !out_tail;
    end
  end

  reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high in the cycle after reset release");
    end

  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_head) && $stable(out_tail) &&
                                $stable(out_word))
    else begin
      fail_count++;
      $error("output flit changed or dropped while stalled");
    end

  // a head flit exactly when no packet is open.
  head_framing: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (out_head == !in_packet))
    else begin
      fail_count++;
      $error("head flag does not match packet framing");
    end

endmodule

bind noc_dest_filter_top noc_dest_filter_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_head  (out_head),
  .out_tail  (out_tail),
  .out_word  (out_word),
  .out_ready (out_ready)
);

`default_nettype wire

// File: noc_dest_filter_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_dest_filter_tb import noc_pkg::*; ();

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             in_head;
  logic             in_tail;
  noc_flit_word_u   in_word;
  logic             in_ready;
  logic             out_valid;
  logic             out_head;
  logic             out_tail;
  noc_flit_word_u   out_word;
  logic             out_ready;

  logic [33:0]      stim_q[$];  // {head, tail, word}.
  logic [33:0]      exp_q[$];
  logic [33:0]      exp_flit;
  int               errors;
  int               n_checked;
  int               n_directed;
  int               watchdog_ns;
  bit               stim_built;
  bit               stall_en;
  noc_packet_type_e ptype;

  noc_dest_filter_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_head   (in_head),
    .in_tail   (in_tail),
    .in_word   (in_word),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_head  (out_head),
    .out_tail  (out_tail),
    .out_word  (out_word),
    .out_ready (out_ready)
  );

  always #10 clk = ~clk;

  always begin
    @(posedge clk);
    #1;
    out_ready = stall_en ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  // request flits, plus whatever should come back for them.
  task automatic add_packet(input noc_packet_type_e pkt_type, input logic [1:0] dx,
                            input logic [1:0] dy, input logic inv, input logic [3:0] bl);
    noc_header_t h;
    noc_header_t rsp;
    logic        bad_dest;
    logic [3:0]  beats;
    logic [31:0] word;
    int          n_pay;
    h = noc_header_t'($urandom);  // random spare bits.
    h.packet_type         = pkt_type;
    h.dest_x              = dx;
    h.dest_y              = dy;
    h.src_x               = 2'($urandom_range(0, `NOC_SIZE_X - 1));
    h.src_y               = 2'($urandom_range(0, `NOC_SIZE_Y - 1));
    h.invalid_destination = inv;
    h.burst_length        = bl;
    h.status              = noc_okay;
    n_pay    = (pkt_type == noc_write || pkt_type == noc_posted_write) ? int'(bl) : 0;
    bad_dest = inv || (int'(dx) >= `NOC_SIZE_X) || (int'(dy) >= `NOC_SIZE_Y);
    stim_q.push_back({1'b1, n_pay == 0, h});
    if (!bad_dest) begin
      exp_q.push_back({1'b1, n_pay == 0, h});
    end
    for (int i = 0; i < n_pay; i++) begin
      word = $urandom;
      stim_q.push_back({1'b0, i == n_pay - 1, word});
      if (!bad_dest) begin
        exp_q.push_back({1'b0, i == n_pay - 1, word});
      end
    end
    if (bad_dest && (pkt_type == noc_read || pkt_type == noc_write)) begin
      beats = (pkt_type == noc_read) ? bl : 4'd0;
      rsp = '0;
      rsp.packet_type  = (pkt_type == noc_read) ? noc_response_with_data : noc_response;
      rsp.dest_x       = h.src_x;
      rsp.dest_y       = h.src_y;
      rsp.src_x        = dx;
      rsp.src_y        = dy;
      rsp.tag          = h.tag;
      rsp.burst_length = beats;
      rsp.status       = noc_decode_error;
      exp_q.push_back({1'b1, beats == 4'd0, rsp});
      for (int i = 0; i < int'(beats); i++) begin
        exp_q.push_back({1'b0, i == int'(beats) - 1, 32'(`NOC_ERROR_DATA)});
      end
    end
  endtask

  task automatic send_flit(input logic [33:0] flit);
    in_valid     = 1'b1;
    in_head      = flit[33];
    in_tail      = flit[32];
    in_word.data = flit[31:0];
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);  // taken on this edge.
    #1;
    in_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("unexpected output flit at %0t ns, nothing left to expect", $time);
      end
      if (exp_q.size() != 0) begin
        exp_flit = exp_q.pop_front();
        n_checked++;
        assert ({out_head, out_tail, out_word.data} == exp_flit) else begin
          errors++;
          $display("[FAIL] %0t ns: flit %0d got %0b %0b %08h, expected %0b %0b %08h",
                   $time, n_checked, out_head, out_tail, out_word.data,
                   exp_flit[33], exp_flit[32], exp_flit[31:0]);
        end
      end
    end
  end

  initial begin
    wait (stim_built);
    #(watchdog_ns);
    $display("timeout: output still not drained after %0d ns", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(52692));
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_head   = 1'b0;
    in_tail   = 1'b0;
    in_word   = '0;
    out_ready = 1'b1;
    stall_en  = 1'b0;
    errors    = 0;
    n_checked = 0;

    add_packet(noc_read, 2'd1, 2'd2, 1'b0, 4'd2);
    add_packet(noc_write, 2'd0, 2'd0, 1'b0, 4'd3);
    add_packet(noc_posted_write, 2'd2, 2'd1, 1'b0, 4'd1);
    add_packet(noc_response, 2'd2, 2'd2, 1'b0, 4'd0);
    add_packet(noc_response_with_data, 2'd0, 2'd1, 1'b0, 4'd2);
    add_packet(noc_write, 2'd1, 2'd0, 1'b0, 4'd0);
    // misrouted traffic.
    add_packet(noc_posted_write, 2'd1, 2'd1, 1'b1, 4'd2);  // flag only.
    add_packet(noc_posted_write, 2'd3, 2'd0, 1'b0, 4'd1);
    add_packet(noc_read, 2'd0, 2'd3, 1'b0, 4'd3);
    add_packet(noc_read, 2'd1, 2'd1, 1'b1, 4'd0);
    add_packet(noc_write, 2'd3, 2'd2, 1'b0, 4'd2);
    add_packet(noc_posted_write, 2'd2, 2'd0, 1'b0, 4'd2);
    n_directed = stim_q.size();
    for (int p = 0; p < 60; p++) begin
      case ($urandom_range(0, 4))
        0:       ptype = noc_read;
        1:       ptype = noc_write;
        2:       ptype = noc_posted_write;
        3:       ptype = noc_response;
        default: ptype = noc_response_with_data;
      endcase
      add_packet(ptype, 2'($urandom_range(0, 3)), 2'($urandom_range(0, 3)),
                 $urandom_range(0, 7) == 0, 4'($urandom_range(0, 4)));
    end
    watchdog_ns = (stim_q.size() + exp_q.size()) * 40 * 20 + 2000;
    stim_built  = 1'b1;

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (stim_q[i]) begin
      if (i == n_directed) begin
        stall_en = 1'b1;  // random mix with back-pressure from here.
      end
      if (stall_en && $urandom_range(0, 3) == 0) begin
        @(posedge clk);
        #1;
      end
      send_flit(stim_q[i]);
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);  // room for stray flits.
    $display("errors: %0d, property failures: %0d, flits sent: %0d, flits checked: %0d",
             errors, u_dut.u_props.fail_count, stim_q.size(), n_checked);
    if (errors == 0 && u_dut.u_props.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: noc_dest_filter_top.sv
`default_nettype none
`timescale 1ns/10ps

module noc_dest_filter_top import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  logic           in_head,
  input  logic           in_tail,
  input  noc_flit_word_u in_word,
  output logic           in_ready,
  output logic           out_valid,
  output logic           out_head,
  output logic           out_tail,
  output noc_flit_word_u out_word,
  input  logic           out_ready
);

  logic           fwd_valid;
  logic           fwd_head;
  logic           fwd_tail;
  noc_flit_word_u fwd_word;
  logic           fwd_ready;

  noc_dest_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_head   (in_head),
    .in_tail   (in_tail),
    .in_word   (in_word),
    .in_ready  (in_ready),
    .fwd_valid (fwd_valid),
    .fwd_head  (fwd_head),
    .fwd_tail  (fwd_tail),
    .fwd_word  (fwd_word),
    .fwd_ready (fwd_ready)
  );

  noc_flit_slicer u_slicer (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (fwd_valid),
    .in_head   (fwd_head),
    .in_tail   (fwd_tail),
    .in_word   (fwd_word),
    .in_ready  (fwd_ready),
    .out_valid (out_valid),
    .out_head  (out_head),
    .out_tail  (out_tail),
    .out_word  (out_word),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: noc_error_request_sink.sv
`default_nettype none
`timescale 1ns/10ps

module noc_error_request_sink import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_valid,
  input  logic           req_head,
  input  logic           req_tail,
  input  noc_flit_word_u req_word,
  output logic           req_ready,
  output logic           hdr_valid,
  output noc_header_t    hdr,
  input  logic           hdr_taken
);

  logic draining;
  logic req_fire;

  // payload keeps flowing behind a waiting header.
  assign req_ready = draining || !hdr_valid;
  assign req_fire  = req_valid && req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hdr_valid <= 1'b0;
      draining  <= 1'b0;
    end else begin
      if (req_fire && req_head) begin
        hdr_valid <= 1'b1;
      end else if (hdr_taken) begin
        hdr_valid <= 1'b0;
      end
      if (req_fire) begin
        draining <= !req_tail;  // open until the tail.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire && req_head) begin
      hdr <= req_word.header;
    end
  end

endmodule

`default_nettype wire

// File: noc_error_response_packer.sv
`default_nettype none
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_error_response_packer import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           rsp_start,
  input  noc_header_t    rsp_hdr,
  input  logic [3:0]     rsp_beats,
  output logic           rsp_valid,
  output logic           rsp_head,
  output logic           rsp_tail,
  output noc_flit_word_u rsp_word,
  input  logic           rsp_ready,
  output logic           rsp_done
);

  noc_header_t hdr_q;
  logic        head_pending;
  logic [3:0]  beats_left;
  logic        rsp_fire;

  assign rsp_fire = rsp_valid && rsp_ready;
  assign rsp_head = head_pending;
  assign rsp_tail = head_pending ? (beats_left == 4'd0) : (beats_left == 4'd1);
  assign rsp_done = rsp_fire && rsp_tail;

  always_comb begin
    if (head_pending) begin
      rsp_word.header = hdr_q;
    end else begin
      rsp_word.data = `NOC_ERROR_DATA;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid    <= 1'b0;
      head_pending <= 1'b0;
      beats_left   <= 4'd0;
    end else if (rsp_start) begin
      rsp_valid    <= 1'b1;
      head_pending <= 1'b1;
      beats_left   <= rsp_beats;
    end else if (rsp_fire) begin
      if (rsp_tail) begin
        rsp_valid <= 1'b0;
      end
      if (head_pending) begin
        head_pending <= 1'b0;
      end else begin
        beats_left <= beats_left - 4'd1;  // one data beat gone.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_start) begin
      hdr_q <= rsp_hdr;
    end
  end

endmodule

`default_nettype wire

// File: noc_flit_slicer.sv
`default_nettype none
`timescale 1ns/10ps

module noc_flit_slicer import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  logic           in_head,
  input  logic           in_tail,
  input  noc_flit_word_u in_word,
  output logic           in_ready,
  output logic           out_valid,
  output logic           out_head,
  output logic           out_tail,
  output noc_flit_word_u out_word,
  input  logic           out_ready
);

  logic           skid_valid;
  logic           skid_head;
  logic           skid_tail;
  noc_flit_word_u skid_word;
  logic           out_load;
  logic           skid_load;

  assign in_ready  = !skid_valid;  // registered ready.
  assign out_load  = !out_valid || out_ready;
  assign skid_load = in_valid && in_ready && !out_load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      out_valid  <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      if (skid_valid) begin
        out_head <= skid_head;
        out_tail <= skid_tail;
        out_word <= skid_word;
      end else begin
        out_head <= in_head;
        out_tail <= in_tail;
        out_word <= in_word;
      end
    end
    if (skid_load) begin  // output stalled, park the flit.
      skid_head <= in_head;
      skid_tail <= in_tail;
      skid_word <= in_word;
    end
  end

endmodule

`default_nettype wire

// File: noc_pkg.sv
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;

  typedef enum logic [2:0] {
    noc_read               = 3'd0,
    noc_write              = 3'd1,
    noc_posted_write       = 3'd2,
    noc_response           = 3'd3,
    noc_response_with_data = 3'd4,
    noc_invalid_packet     = 3'd7
  } noc_packet_type_e;

  typedef enum logic [1:0] {
    noc_okay         = 2'd0,
    noc_decode_error = 2'd1
  } noc_status_e;

  typedef struct packed {
    noc_packet_type_e             packet_type;
    logic [`NOC_COORD_WIDTH-1:0]  dest_x;
    logic [`NOC_COORD_WIDTH-1:0]  dest_y;
    logic [`NOC_COORD_WIDTH-1:0]  src_x;
    logic [`NOC_COORD_WIDTH-1:0]  src_y;
    logic                         invalid_destination;
    logic [3:0]                   tag;
    logic [3:0]                   burst_length;  // payload beats.
    noc_status_e                  status;
    logic [`NOC_DATA_WIDTH-23:0]  spare;         // 22 bits in use above.
  } noc_header_t;

  // one flit word, seen as a header on head flits and as data otherwise.
  typedef union packed {
    noc_header_t                 header;
    logic [`NOC_DATA_WIDTH-1:0]  data;
  } noc_flit_word_u;

  function automatic logic is_non_posted(noc_packet_type_e packet_type);
    return (packet_type == noc_read) || (packet_type == noc_write);
  endfunction

  function automatic logic has_payload(noc_packet_type_e packet_type);
    return (packet_type == noc_write) || (packet_type == noc_posted_write);
  endfunction

  // only a read gets data back.
  function automatic logic response_has_data(noc_packet_type_e packet_type);
    return packet_type == noc_read;
  endfunction

endpackage

`default_nettype wire

// File: noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// mesh dimensions.
`define NOC_SIZE_X 3
`define NOC_SIZE_Y 3

// coordinate field width. 3 still fits, but is outside the mesh.
`define NOC_COORD_WIDTH 2

`define NOC_DATA_WIDTH 32

// data beat returned by an errored read.
`define NOC_ERROR_DATA 32'hbad0_dec0

`endif

// File: verilog.f
+incdir+.
noc_pkg.sv
noc_error_request_sink.sv
noc_error_response_packer.sv
noc_dest_checker.sv
noc_flit_slicer.sv
noc_dest_filter_top.sv
noc_dest_filter_properties.sv
noc_dest_filter_tb.sv
